/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_risc5_soc
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SOURCES   := $(shell cat $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

/* bio.sv */
// board I/O: 8 LEDs out, 8 switches in
// switch reads lag the pins by two clocks
module bio (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t req,
  input  logic              en,
  input  logic [7:0]        swi,
  output logic [7:0]        led,
  output logic [31:0]       rdata
);

  logic [7:0] swi_meta;
  logic [7:0] swi_sync;

  // two-stage synchroniser for the switch pins
  always_ff @(posedge clk) begin
    swi_meta <= swi;
    swi_sync <= swi_meta;
  end

  // led register, byte 0 of the written word
  always_ff @(posedge clk) begin
    if (rst) begin
      led <= 8'h0;
    end else if (en && req.wr) begin
      led <= req.wdata[7:0];
    end
  end

  // led readback in byte 1
  assign rdata = {16'h0, led, swi_sync};

endmodule

/* bus_decode.sv */
// address decoder and read mux, purely combinational
// unmapped reads return 0 and unmapped writes reach no slave
module bus_decode (
  input  bus_pkg::bus_req_t req,
  input  logic [31:0]       ram_rdata,
  input  logic              ram_wait,
  input  logic [31:0]       tmr_count,
  input  logic [31:0]       bio_rdata,
  input  logic [31:0]       ser_data,
  input  logic [31:0]       ser_status,
  output logic              ram_en,
  output logic              bio_en,
  output logic              ser_data_en,
  output logic              ser_ctrl_en,
  output logic [31:0]       rdata,
  output logic              memwait
);
  import bus_pkg::*;
  import io_pkg::*;

  region_e  region;
  io_slot_e slot;

  // ------------------------------
  // region and slot
  // ------------------------------

  always_comb begin
    if (req.adr[23:20] == RAM_REGION) begin
      region = region_ram;
    end else if (req.adr[23:6] == IO_BASE_HI) begin
      region = region_io;
    end else begin
      region = region_none;
    end
  end

  // word slot inside the I/O block
  assign slot = io_slot_e'(req.adr[5:2]);

  // one enable per slave, timer has none
  assign ram_en      = (region == region_ram);
  assign bio_en      = (region == region_io) && (slot == slot_bio);
  assign ser_data_en = (region == region_io) && (slot == slot_ser_data);
  assign ser_ctrl_en = (region == region_io) && (slot == slot_ser_status);

  // ------------------------------
  // read mux
  // ------------------------------

  always_comb begin
    rdata = 32'h0;
    case (region)
      region_ram: rdata = ram_rdata;
      region_io: begin
        case (slot)
          slot_tmr:        rdata = tmr_count;
          slot_bio:        rdata = bio_rdata;
          slot_ser_data:   rdata = ser_data;
          slot_ser_status: rdata = ser_status;
          default:         rdata = 32'h0;
        endcase
      end
      default: rdata = 32'h0;
    endcase
  end

  // only ram reads ever stall
  assign memwait = (region == region_ram) ? ram_wait : 1'b0;

  // master protocol and decoder exclusivity
  always_comb begin
    assert final (!(req.rd && req.wr));
    assert final ($onehot0({ram_en, bio_en, ser_data_en, ser_ctrl_en}));
  end

endmodule

/* bus_pkg.sv */
// bus request type and address map for the CPU-side memory bus
// rd and wr are never high together; byte writes use wdata[7:0]
package bus_pkg;

  // ------------------------------
  // master request
  // ------------------------------

  typedef struct packed {
    // byte address
    logic [23:0] adr;
    logic        rd;
    logic        wr;
    // byte write, lane from adr[1:0]
    logic        ben;
    logic [31:0] wdata;
  } bus_req_t;

  // ------------------------------
  // address map
  // ------------------------------

  // decoder result for one access
  typedef enum logic [1:0] {
    region_ram,
    region_io,
    region_none
  } region_e;

  // adr[23:6] of the top 64 bytes
  localparam logic [17:0] IO_BASE_HI = 18'h3ffff;
  // adr[23:20] for ram
  localparam logic [3:0]  RAM_REGION = 4'h0;

endpackage

/* io_pkg.sv */
// I/O slot numbers and serial port encodings
// slots are word addresses within the I/O region, taken from adr[5:2]
package io_pkg;

  // word slots in the I/O region
  typedef enum logic [3:0] {
    slot_tmr        = 4'd0,
    slot_bio        = 4'd1,
    slot_ser_data   = 4'd2,
    slot_ser_status = 4'd3
  } io_slot_e;

  // shared by tx and rx FSMs
  typedef enum logic [1:0] {
    idle,
    start,
    data,
    stop
  } ser_state_e;

  // status word bits
  localparam int SER_RX_READY = 0;
  localparam int SER_TX_BUSY  = 1;

endpackage

/* list.f */
bus_pkg.sv
io_pkg.sv
bus_decode.sv
ram.sv
tmr.sv
bio.sv
ser.sv
risc5_soc.sv
tb_risc5_soc.sv

/* ram.sv */
// word RAM, 2**RAM_AW words; addresses above that alias
// reads stall one cycle, writes complete without wait
module ram #(
  parameter int RAM_AW = 10
) (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t req,
  input  logic              en,
  output logic [31:0]       rdata,
  output logic              wait_req
);

  logic [31:0]       mem [0:(2**RAM_AW)-1];
  logic [RAM_AW-1:0] widx;
  logic [1:0]        lane;
  logic [3:0]        lane_we;
  logic [31:0]       wword;
  // read already waited once
  logic              pending;

  assign widx = req.adr[RAM_AW+1:2];
  assign lane = req.adr[1:0];

  // byte write replicates wdata[7:0] on all lanes, mask picks one
  always_comb begin
    if (req.ben) begin
      lane_we = 4'b0001 << lane;
      wword   = {4{req.wdata[7:0]}};
    end else begin
      lane_we = 4'b1111;
      wword   = req.wdata;
    end
  end

  // ------------------------------
  // array access
  // ------------------------------

  always_ff @(posedge clk) begin
    if (en && req.wr) begin
      for (int i = 0; i < 4; i++) begin
        if (lane_we[i]) begin
          mem[widx][8*i +: 8] <= wword[8*i +: 8];
        end
      end
    end
    // full word always, ben ignored on reads
    if (en && req.rd) begin
      rdata <= mem[widx];
    end
  end

  // set after first read cycle, dropped with rd
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else begin
      pending <= en && req.rd;
    end
  end

  assign wait_req = en && req.rd && !pending;

  // a held read stalls only once
  assert property (@(posedge clk) disable iff (rst) wait_req |=> !wait_req);

endmodule

/* risc5_soc.sv */
// memory and I/O fabric of the RISC5 system, CPU not included
// one clock domain; swi and rxd are synchronised inside the slaves
module risc5_soc #(
  parameter int RAM_AW       = 10,
  parameter int TICK_DIV     = 25,
  parameter int CLKS_PER_BIT = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t req,
  output logic [31:0]       rdata,
  output logic              memwait,
  output logic              txd,
  input  logic              rxd,
  input  logic [7:0]        swi,
  output logic [7:0]        led
);

  // slave enables
  logic        ram_en;
  logic        bio_en;
  logic        ser_data_en;
  logic        ser_ctrl_en;
  // slave read data
  logic [31:0] ram_rdata;
  logic        ram_wait;
  logic [31:0] tmr_count;
  logic [31:0] bio_rdata;
  logic [31:0] ser_data;
  logic [31:0] ser_status;

  // ------------------------------
  // decoder and slaves
  // ------------------------------

  bus_decode dec_1 (
    .req(req), .ram_rdata(ram_rdata), .ram_wait(ram_wait),
    .tmr_count(tmr_count), .bio_rdata(bio_rdata),
    .ser_data(ser_data), .ser_status(ser_status),
    .ram_en(ram_en), .bio_en(bio_en),
    .ser_data_en(ser_data_en), .ser_ctrl_en(ser_ctrl_en),
    .rdata(rdata), .memwait(memwait)
  );

  ram #(.RAM_AW(RAM_AW)) ram_1 (
    .clk(clk), .rst(rst), .req(req), .en(ram_en),
    .rdata(ram_rdata), .wait_req(ram_wait)
  );

  tmr #(.TICK_DIV(TICK_DIV)) tmr_1 (
    .clk(clk), .rst(rst), .count(tmr_count)
  );

  bio bio_1 (
    .clk(clk), .rst(rst), .req(req), .en(bio_en),
    .swi(swi), .led(led), .rdata(bio_rdata)
  );

  ser #(.CLKS_PER_BIT(CLKS_PER_BIT)) ser_1 (
    .clk(clk), .rst(rst), .req(req),
    .data_en(ser_data_en), .ctrl_en(ser_ctrl_en),
    .rxd(rxd), .txd(txd), .rdata(ser_data), .status(ser_status)
  );

endmodule

/* ser.sv */
// 8N1 serial port, CLKS_PER_BIT clocks per bit, at least 2
// tx drops writes while busy; an unread rx byte is overwritten
module ser #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t req,
  input  logic              data_en,
  input  logic              ctrl_en,
  input  logic              rxd,
  output logic              txd,
  output logic [31:0]       rdata,
  output logic [31:0]       status
);
  import io_pkg::*;

  localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  ser_state_e    tx_state;
  logic [CW-1:0] tx_cnt;
  logic [2:0]    tx_bit;
  logic [7:0]    tx_shift;
  logic          tx_last;
  logic          tx_busy;
  logic          tx_load;
  ser_state_e    rx_state;
  logic [CW-1:0] rx_cnt;
  logic [2:0]    rx_bit;
  logic [7:0]    rx_shift;
  logic [7:0]    rx_byte;
  logic          rx_meta;
  logic          rx_sync;
  logic          rx_half;
  logic          rx_full;
  logic          rx_done;
  logic          rx_ready;

  // ------------------------------
  // transmitter
  // ------------------------------

  assign tx_busy = (tx_state != idle);
  assign tx_load = (tx_state == idle) && data_en && req.wr;
  assign tx_last = (tx_cnt == CW'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_state <= idle;
      tx_cnt   <= '0;
      tx_bit   <= 3'd0;
      txd      <= 1'b1;
    end else begin
      tx_cnt <= tx_last ? '0 : tx_cnt + CW'(1);
      case (tx_state)
        idle: begin
          tx_cnt <= '0;
          if (tx_load) begin
            // start bit from the next clock
            tx_state <= start;
            txd      <= 1'b0;
          end
        end
        start: begin
          if (tx_last) begin
            tx_state <= data;
            tx_bit   <= 3'd0;
            txd      <= tx_shift[0];
          end
        end
        data: begin
          if (tx_last) begin
            if (tx_bit == 3'd7) begin
              tx_state <= stop;
              txd      <= 1'b1;
            end else begin
              // shift happens on this same edge
              tx_bit <= tx_bit + 3'd1;
              txd    <= tx_shift[1];
            end
          end
        end
        default: begin
          if (tx_last) begin
            tx_state <= idle;
          end
        end
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk) begin
    if (tx_load) begin
      tx_shift <= req.wdata[7:0];
    end else if ((tx_state == data) && tx_last) begin
      tx_shift <= {1'b0, tx_shift[7:1]};
    end
  end

  // ------------------------------
  // receiver
  // ------------------------------

  // counts from the start edge, so the full count lands mid-bit
  assign rx_half = (rx_cnt == CW'(CLKS_PER_BIT / 2 - 1));
  assign rx_full = (rx_cnt == CW'(CLKS_PER_BIT - 1));
  // mid-stop sample must be high
  assign rx_done = (rx_state == stop) && rx_full && rx_sync;

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_state <= idle;
      rx_cnt   <= '0;
      rx_bit   <= 3'd0;
      rx_ready <= 1'b0;
    end else begin
      rx_meta <= rxd;
      rx_sync <= rx_meta;
      rx_cnt  <= rx_full ? '0 : rx_cnt + CW'(1);
      case (rx_state)
        idle: begin
          rx_cnt <= '0;
          if (!rx_sync) begin
            rx_state <= start;
          end
        end
        start: begin
          if (rx_half) begin
            rx_cnt <= '0;
            // glitch shorter than half a bit goes back to idle
            rx_state <= rx_sync ? idle : data;
            rx_bit   <= 3'd0;
          end
        end
        data: begin
          if (rx_full) begin
            rx_bit <= rx_bit + 3'd1;
            if (rx_bit == 3'd7) begin
              rx_state <= stop;
            end
          end
        end
        default: begin
          if (rx_full) begin
            rx_state <= idle;
          end
        end
      endcase
      // new byte wins over a same-cycle read
      if (rx_done) begin
        rx_ready <= 1'b1;
      end else if ((data_en && req.rd) || (ctrl_en && req.wr)) begin
        rx_ready <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((rx_state == data) && rx_full) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
    if (rx_done) begin
      rx_byte <= rx_shift;
    end
  end

  // ------------------------------
  // bus side
  // ------------------------------

  assign rdata = {24'h0, rx_byte};

  always_comb begin
    status               = 32'h0;
    status[SER_RX_READY] = rx_ready;
    status[SER_TX_BUSY]  = tx_busy;
  end

  // line idles high between frames
  assert property (@(posedge clk) disable iff (rst) (tx_state == idle) |-> txd);

endmodule

/* tb_risc5_soc.sv */
// testbench for risc5_soc with random bus traffic from a fixed-seed LFSR
// txd loops back to rxd; RAM reads only touch words written earlier in the run
module tb_risc5_soc;
  timeunit 1ns;
  timeprecision 1ps;
  import bus_pkg::*;
  import io_pkg::*;

  localparam int RAM_AW       = 10;
  localparam int TICK_DIV     = 25;
  localparam int CLKS_PER_BIT = 8;
  localparam int CLK_PERIOD   = 100;
  localparam int WAIT_LIMIT   = 8;
  localparam int POLL_LIMIT   = 200;
  localparam int NWORDS       = 64;

  logic        clk;
  logic        rst;
  bus_req_t    req;
  logic [31:0] rdata;
  logic        memwait;
  logic        txd;
  logic        rxd;
  logic [7:0]  swi;
  logic [7:0]  led;

  logic [31:0] lfsr;
  // reference model of the RAM contents
  logic [31:0] shadow [0:(2**RAM_AW)-1];
  logic [23:0] addr_list [0:NWORDS-1];
  int          order [0:NWORDS-1];
  time         sample_time;
  logic [7:0]  led_model;
  int          errors;
  int          tests;

  risc5_soc #(
    .RAM_AW(RAM_AW), .TICK_DIV(TICK_DIV), .CLKS_PER_BIT(CLKS_PER_BIT)
  ) dut0 (
    .clk(clk), .rst(rst), .req(req), .rdata(rdata), .memwait(memwait),
    .txd(txd), .rxd(rxd), .swi(swi), .led(led)
  );

  // serial loopback
  assign rxd = txd;

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------
  // random numbers
  // ------------------------------

  // galois step with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  // one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = 32'h0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [23:0] io_addr(input logic [3:0] slot);
    return {IO_BASE_HI, slot, 2'b00};
  endfunction

  // ------------------------------
  // reporting
  // ------------------------------

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Error at %0d ns: %s is %h, expected %h", $time, sig, got, exp);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("failure at %0d ns: %s", $time, msg);
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout at %0d ns while waiting for %s", $time, what);
    $display("Test failed");
    $finish;
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    tests++;
    $display("%s finished with %0d errors", name, errors - errs_at_start);
  endtask

  // ------------------------------
  // bus master
  // ------------------------------

  // drive after the edge and sample at the falling edge
  // the bus idles one cycle after each access
  task automatic bus_write(input logic [23:0] adr, input logic [31:0] wdata,
                           input logic ben);
    int cnt;
    @(posedge clk);
    #1;
    req.adr   = adr;
    req.rd    = 1'b0;
    req.wr    = 1'b1;
    req.ben   = ben;
    req.wdata = wdata;
    cnt       = 0;
    @(negedge clk);
    while (memwait) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        timeout_fail("memwait to fall on a write");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req = '0;
  endtask

  // waits counts the cycles with memwait high
  task automatic bus_read(input logic [23:0] adr, output logic [31:0] data,
                          output int waits);
    @(posedge clk);
    #1;
    req.adr   = adr;
    req.rd    = 1'b1;
    req.wr    = 1'b0;
    req.ben   = 1'b0;
    req.wdata = 32'h0;
    waits     = 0;
    @(negedge clk);
    while (memwait) begin
      waits++;
      if (waits > WAIT_LIMIT) begin
        timeout_fail("memwait to fall on a read");
      end
      @(negedge clk);
    end
    data        = rdata;
    sample_time = $time;
    @(posedge clk);
    #1;
    req = '0;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    int          e0;
    int          w;
    int          j;
    int          k;
    int          n;
    int          lo;
    int          polls;
    time         s0;
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] st;
    logic [23:0] a;
    logic [3:0]  nib;
    logic [7:0]  tx_byte;

    clk       = 1'b0;
    rst       = 1'b1;
    req       = '0;
    swi       = 8'h0;
    lfsr      = 32'hfa4017bc;
    led_model = 8'h0;
    errors    = 0;
    tests     = 0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // timer first so its read is the first after reset
    e0 = errors;
    bus_read(io_addr(slot_tmr), t0, w);
    if ($isunknown(t0) || t0 > 32'd2) begin
      report_failure("timer count is not small right after reset");
    end
    for (int i = 0; i < 4; i++) begin
      bus_read(io_addr(slot_tmr), t0, w);
      s0 = sample_time;
      r  = take_bits(8);
      repeat (int'(r[7:0]) + 20) @(posedge clk);
      bus_read(io_addr(slot_tmr), t1, w);
      n  = int'((sample_time - s0) / CLK_PERIOD);
      lo = n / TICK_DIV;
      if ((t1 - t0) !== 32'(lo) && (t1 - t0) !== 32'(lo + 1)) begin
        report_mismatch("timer delta", t1 - t0, 32'(lo));
      end
    end
    end_test("timer", e0);

    // random words where upper address bits alias
    e0 = errors;
    for (int i = 0; i < NWORDS; i++) begin
      r            = take_bits(18);
      addr_list[i] = {4'h0, r[17:0], 2'b00};
      d            = take_bits(32);
      bus_write(addr_list[i], d, 1'b0);
      shadow[addr_list[i][RAM_AW+1:2]] = d;
      order[i] = i;
    end
    // shuffle the read order
    for (int i = NWORDS - 1; i > 0; i--) begin
      j        = int'(take_bits(6)) % (i + 1);
      k        = order[i];
      order[i] = order[j];
      order[j] = k;
    end
    for (int i = 0; i < NWORDS; i++) begin
      a = addr_list[order[i]];
      bus_read(a, d, w);
      if (d !== shadow[a[RAM_AW+1:2]]) begin
        report_mismatch("rdata", d, shadow[a[RAM_AW+1:2]]);
      end
      if (w != 1) begin
        report_mismatch("memwait cycles", 32'(w), 32'd1);
      end
    end
    end_test("ram words", e0);

    // byte lanes with upper wdata bits ignored
    e0 = errors;
    for (int i = 0; i < 32; i++) begin
      j = int'(take_bits(6));
      r = take_bits(2);
      a = {addr_list[j][23:2], r[1:0]};
      d = take_bits(32);
      bus_write(a, d, 1'b1);
      shadow[a[RAM_AW+1:2]][8*r[1:0] +: 8] = d[7:0];
      bus_read({a[23:2], 2'b00}, t0, w);
      if (t0 !== shadow[a[RAM_AW+1:2]]) begin
        report_mismatch("rdata", t0, shadow[a[RAM_AW+1:2]]);
      end
    end
    end_test("byte writes", e0);

    // unmapped space outside ram and the I/O block
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      r   = take_bits(3);
      nib = {1'b0, r[2:0]} + 4'd1;
      j   = int'(take_bits(6));
      a   = {nib, addr_list[j][19:0]};
      bus_write(a, take_bits(32), 1'b0);
      bus_read(a, d, w);
      if (d !== 32'h0) begin
        report_mismatch("rdata", d, 32'h0);
      end
      if (w != 0) begin
        report_mismatch("memwait cycles", 32'(w), 32'd0);
      end
      bus_read(addr_list[j], d, w);
      if (d !== shadow[addr_list[j][RAM_AW+1:2]]) begin
        report_mismatch("rdata", d, shadow[addr_list[j][RAM_AW+1:2]]);
      end
      // unused I/O slots 4 to 11
      r = take_bits(3);
      a = io_addr({1'b0, r[2:0]} + 4'd4);
      bus_write(a, take_bits(32), 1'b0);
      bus_read(a, d, w);
      if (d !== 32'h0) begin
        report_mismatch("rdata", d, 32'h0);
      end
      if (led !== led_model) begin
        report_mismatch("led", {24'h0, led}, {24'h0, led_model});
      end
      bus_read(io_addr(slot_ser_status), st, w);
      if (st !== 32'h0) begin
        report_mismatch("ser status", st, 32'h0);
      end
      if (txd !== 1'b1) begin
        report_failure("txd left idle level after an unmapped write");
      end
    end
    end_test("unmapped", e0);

    // leds out and switches in
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      d         = take_bits(32);
      led_model = d[7:0];
      bus_write(io_addr(slot_bio), d, 1'b0);
      if (led !== led_model) begin
        report_mismatch("led", {24'h0, led}, {24'h0, led_model});
      end
      r = take_bits(8);
      @(posedge clk);
      #1;
      swi = r[7:0];
      // synchroniser depth plus margin
      repeat (3) @(posedge clk);
      bus_read(io_addr(slot_bio), d, w);
      if (d !== {16'h0, led_model, r[7:0]}) begin
        report_mismatch("rdata", d, {16'h0, led_model, r[7:0]});
      end
    end
    end_test("board io", e0);

    // serial loopback through txd and rxd
    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      r       = take_bits(8);
      tx_byte = r[7:0];
      bus_write(io_addr(slot_ser_data), {24'h0, tx_byte}, 1'b0);
      bus_read(io_addr(slot_ser_status), st, w);
      if (st[SER_TX_BUSY] !== 1'b1) begin
        report_failure("tx_busy not set after a write to the data slot");
      end
      // dropped while the frame is going out
      bus_write(io_addr(slot_ser_data), {24'h0, ~tx_byte}, 1'b0);
      polls = 0;
      st    = 32'h0;
      while (st[SER_RX_READY] !== 1'b1) begin
        polls++;
        if (polls > POLL_LIMIT) begin
          timeout_fail("rx_ready on the serial loopback");
        end
        bus_read(io_addr(slot_ser_status), st, w);
      end
      bus_read(io_addr(slot_ser_data), d, w);
      if (d !== {24'h0, tx_byte}) begin
        report_mismatch("ser rdata", d, {24'h0, tx_byte});
      end
      bus_read(io_addr(slot_ser_status), st, w);
      if (st[SER_RX_READY] !== 1'b0) begin
        report_failure("rx_ready still set after reading the data slot");
      end
      polls = 0;
      while (st[SER_TX_BUSY] !== 1'b0) begin
        polls++;
        if (polls > POLL_LIMIT) begin
          timeout_fail("tx_busy to clear");
        end
        bus_read(io_addr(slot_ser_status), st, w);
      end
      // a second frame would show up within this quiet time
      repeat (12 * CLKS_PER_BIT) @(posedge clk);
      bus_read(io_addr(slot_ser_status), st, w);
      if (st !== 32'h0) begin
        report_mismatch("ser status", st, 32'h0);
      end
    end
    end_test("serial", e0);

    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tmr.sv */
// free-running tick counter, one tick per TICK_DIV clocks
// count wraps at 2**32 ticks
module tmr #(
  parameter int TICK_DIV = 25
) (
  input  logic        clk,
  input  logic        rst,
  output logic [31:0] count
);

  // prescaler needs at least one bit
  localparam int PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [PW-1:0] pre;

  always_ff @(posedge clk) begin
    if (rst) begin
      pre   <= '0;
      count <= 32'h0;
    end else if (pre == PW'(TICK_DIV - 1)) begin
      // wrap and tick
      pre   <= '0;
      count <= count + 32'd1;
    end else begin
      pre   <= pre + PW'(1);
    end
  end

endmodule
